/* lsu_macros.svh */
// width definitions shared by the load/store unit packages and RTL
// include this file wherever an address, data or byte enable width is needed

`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

//////////////////////////////
// bus widths
//////////////////////////////

// byte address, word aligned on the bus
`define LSU_ADDR_W 32

// load and store data
`define LSU_DATA_W 32

// one enable per data byte
`define LSU_BE_W 4

`endif

/* lsu_pkg.sv */
// core side types of the load/store unit
// covers the execute stage request, the response and the sequencer state

`include "lsu_macros.svh"

package lsu_pkg;

  // access size, byte also accepts 2'b11
  typedef enum logic [1:0] {
    SIZE_WORD = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_BYTE = 2'b10
  } lsu_size_e;

  typedef enum logic [2:0] {
    IDLE,
    WAIT_GNT,
    WAIT_GNT_MIS,              // first part of a split access not granted yet
    WAIT_RVALID_MIS,           // second part pending, first rvalid outstanding
    WAIT_RVALID_MIS_GNTS_DONE  // both granted, first rvalid outstanding
  } ls_fsm_e;

  typedef struct packed {
    logic                   req;
    logic                   we;
    lsu_size_e              size;
    logic                   sign_ext;
    logic [`LSU_ADDR_W-1:0] addr;
    logic [`LSU_DATA_W-1:0] wdata;
  } lsu_req_t;

  typedef struct packed {
    logic                   resp_valid;
    logic                   rdata_valid; // load data to be written back
    logic [`LSU_DATA_W-1:0] rdata;
    logic                   load_err;
    logic                   store_err;
  } lsu_rsp_t;

endpackage

/* mem_pkg.sv */
// data bus types for the request/grant/rvalid interface
// one request is outstanding until gnt, each grant gets one in-order rvalid

`include "lsu_macros.svh"

package mem_pkg;

  typedef struct packed {
    logic                   req;
    logic                   we;
    logic [`LSU_BE_W-1:0]   be;
    logic [`LSU_ADDR_W-1:0] addr;  // word aligned
    logic [`LSU_DATA_W-1:0] wdata;
  } data_req_t;

  typedef struct packed {
    logic                   gnt;
    logic                   rvalid;
    logic                   err;
    logic                   pmp_err; // valid in the request phase
    logic [`LSU_DATA_W-1:0] rdata;
  } data_rsp_t;

endpackage

/* lsu_wdata_align.sv */
// store side of the load/store unit
// makes the byte enables of the current bus part and rotates store data

`include "lsu_macros.svh"

module lsu_wdata_align import lsu_pkg::*; (
  input  lsu_size_e              size_i,
  input  logic [1:0]             offset_i,
  input  logic                   misaligned_part2_i,
  input  logic [`LSU_DATA_W-1:0] wdata_i,
  output logic [`LSU_BE_W-1:0]   be_o,
  output logic [`LSU_DATA_W-1:0] wdata_o
);

  //////////////////////////////
  // byte enables
  //////////////////////////////

  always_comb begin
    unique case (size_i)
      SIZE_WORD: begin
        if (!misaligned_part2_i) begin
          unique case (offset_i)
            2'b00:   be_o = 4'b1111;
            2'b01:   be_o = 4'b1110;
            2'b10:   be_o = 4'b1100;
            default: be_o = 4'b1000;
          endcase
        end else begin // spill into the next word
          unique case (offset_i)
            2'b01:   be_o = 4'b0001;
            2'b10:   be_o = 4'b0011;
            2'b11:   be_o = 4'b0111;
            default: be_o = 4'b0000; // aligned word has no second part
          endcase
        end
      end
      SIZE_HALF: begin
        if (!misaligned_part2_i) begin
          unique case (offset_i)
            2'b00:   be_o = 4'b0011;
            2'b01:   be_o = 4'b0110;
            2'b10:   be_o = 4'b1100;
            default: be_o = 4'b1000;
          endcase
        end else begin
          be_o = 4'b0001; // only offset 3 splits
        end
      end
      default: be_o = 4'b0001 << offset_i; // byte
    endcase
  end

  //////////////////////////////
  // store data rotation
  //////////////////////////////

  // rotate left by offset bytes, both parts of a split store use the same word
  always_comb begin
    unique case (offset_i)
      2'b00:   wdata_o = wdata_i;
      2'b01:   wdata_o = {wdata_i[23:0], wdata_i[31:24]};
      2'b10:   wdata_o = {wdata_i[15:0], wdata_i[31:16]};
      default: wdata_o = {wdata_i[7:0],  wdata_i[31:8]};
    endcase
  end

endmodule

/* lsu_rdata_align.sv */
// load side of the load/store unit
// keeps the access control and the first half of a split load, then
// realigns the bus data and zero- or sign-extends halves and bytes

`include "lsu_macros.svh"

module lsu_rdata_align import lsu_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   ctrl_update_i,
  input  logic                   rdata_update_i,
  input  lsu_size_e              size_i,
  input  logic                   sign_ext_i,
  input  logic [1:0]             offset_i,
  input  logic [`LSU_DATA_W-1:0] rdata_i,
  output logic [`LSU_DATA_W-1:0] rdata_o
);

  logic [1:0]             offset_q;
  lsu_size_e              size_q;
  logic                   sign_ext_q;
  logic [`LSU_DATA_W-1:8] rdata_q;   // upper bytes of the first part

  logic [`LSU_DATA_W-1:0] rdata_w;
  logic [15:0]            half_raw;
  logic [7:0]             byte_raw;

  // access control, captured when a part is granted
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      offset_q   <= 2'b00;
      size_q     <= SIZE_WORD;
      sign_ext_q <= 1'b0;
    end else if (ctrl_update_i) begin
      offset_q   <= offset_i;
      size_q     <= size_i;
      sign_ext_q <= sign_ext_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rdata_update_i) begin
      rdata_q <= rdata_i[`LSU_DATA_W-1:8];
    end
  end

  //////////////////////////////
  // realignment
  //////////////////////////////

  // low bytes come from the first word, high bytes from the current one
  always_comb begin
    unique case (offset_q)
      2'b00:   rdata_w = rdata_i;
      2'b01:   rdata_w = {rdata_i[7:0],  rdata_q[31:8]};
      2'b10:   rdata_w = {rdata_i[15:0], rdata_q[31:16]};
      default: rdata_w = {rdata_i[23:0], rdata_q[31:24]};
    endcase
  end

  always_comb begin
    unique case (offset_q)
      2'b00:   half_raw = rdata_i[15:0];
      2'b01:   half_raw = rdata_i[23:8];
      2'b10:   half_raw = rdata_i[31:16];
      default: half_raw = {rdata_i[7:0], rdata_q[31:24]}; // split half
    endcase
  end

  assign byte_raw = rdata_i[{offset_q, 3'b000} +: 8];

  // size select and extension
  always_comb begin
    unique case (size_q)
      SIZE_WORD: rdata_o = rdata_w;
      SIZE_HALF: rdata_o = {{16{sign_ext_q & half_raw[15]}}, half_raw};
      default:   rdata_o = {{24{sign_ext_q & byte_raw[7]}}, byte_raw};
    endcase
  end

endmodule

/* lsu_ctrl_fsm.sv */
// sequencer of the load/store unit
// issues one or two bus parts per access, tracks bus and PMP errors,
// keeps the last access address for traps and drives the status strobes

`include "lsu_macros.svh"

module lsu_ctrl_fsm import lsu_pkg::*; import mem_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  lsu_req_t               lsu_req_i,
  input  data_rsp_t              data_rsp_i,
  output logic                   bus_req_o,
  output logic                   misaligned_part2_o,
  output logic                   ctrl_update_o,
  output logic                   rdata_update_o,
  output logic                   resp_valid_o,
  output logic                   resp_err_o,
  output logic                   resp_is_wr_o,
  output logic                   lsu_req_done_o,
  output logic                   lsu_addr_incr_req_o,
  output logic [`LSU_ADDR_W-1:0] addr_last_o,
  output logic                   busy_o,
  output logic                   perf_load_o,
  output logic                   perf_store_o
);

  ls_fsm_e                ls_fsm_cs, ls_fsm_ns;
  logic                   split_access;
  logic                   part2_q, part2_d;     // first part granted, second pending
  logic                   pmp_err_q, pmp_err_d;
  logic                   lsu_err_q, lsu_err_d; // error of the first part
  logic                   we_q;
  logic                   lsu_go;
  logic                   addr_update;
  logic [`LSU_ADDR_W-1:0] addr_last_q;
  logic [`LSU_ADDR_W-1:0] addr_w_aligned;

  // word at offset 1..3 or half at offset 3 crosses a word boundary
  assign split_access =
      ((lsu_req_i.size == SIZE_WORD) && (lsu_req_i.addr[1:0] != 2'b00)) ||
      ((lsu_req_i.size == SIZE_HALF) && (lsu_req_i.addr[1:0] == 2'b11));

  assign addr_w_aligned = {lsu_req_i.addr[`LSU_ADDR_W-1:2], 2'b00};

  //////////////////////////////
  // sequencer
  //////////////////////////////

  always_comb begin
    ls_fsm_ns           = ls_fsm_cs;
    bus_req_o           = 1'b0;
    lsu_addr_incr_req_o = 1'b0;
    part2_d             = part2_q;
    pmp_err_d           = pmp_err_q;
    lsu_err_d           = lsu_err_q;
    addr_update         = 1'b0;
    ctrl_update_o       = 1'b0;
    rdata_update_o      = 1'b0;
    perf_load_o         = 1'b0;
    perf_store_o        = 1'b0;
    lsu_go              = 1'b0;

    unique case (ls_fsm_cs)
      IDLE: begin
        pmp_err_d = 1'b0;
        if (lsu_req_i.req) begin
          bus_req_o    = 1'b1;
          pmp_err_d    = data_rsp_i.pmp_err;
          lsu_err_d    = 1'b0;
          perf_load_o  = ~lsu_req_i.we;
          perf_store_o = lsu_req_i.we;
          lsu_go       = 1'b1;
          if (data_rsp_i.gnt) begin
            ctrl_update_o = 1'b1;
            addr_update   = 1'b1;
            part2_d       = split_access;
            ls_fsm_ns     = split_access ? WAIT_RVALID_MIS : IDLE;
          end else begin
            ls_fsm_ns     = split_access ? WAIT_GNT_MIS : WAIT_GNT;
          end
        end
      end

      WAIT_GNT_MIS: begin
        bus_req_o = 1'b1;
        // a PMP-blocked part may never see gnt
        if (data_rsp_i.gnt || pmp_err_q) begin
          ctrl_update_o = 1'b1;
          addr_update   = 1'b1;
          part2_d       = 1'b1;
          ls_fsm_ns     = WAIT_RVALID_MIS;
        end
      end

      WAIT_RVALID_MIS: begin
        bus_req_o           = 1'b1; // second part
        lsu_addr_incr_req_o = 1'b1;
        if (data_rsp_i.rvalid || pmp_err_q) begin
          pmp_err_d      = data_rsp_i.pmp_err;
          lsu_err_d      = data_rsp_i.err | pmp_err_q;
          rdata_update_o = ~we_q;
          ls_fsm_ns      = data_rsp_i.gnt ? IDLE : WAIT_GNT;
          addr_update    = data_rsp_i.gnt & ~(data_rsp_i.err | pmp_err_q);
          part2_d        = ~data_rsp_i.gnt;
        end else if (data_rsp_i.gnt) begin
          ls_fsm_ns = WAIT_RVALID_MIS_GNTS_DONE;
          part2_d   = 1'b0;
        end
      end

      WAIT_GNT: begin
        bus_req_o           = 1'b1;
        lsu_addr_incr_req_o = part2_q;
        if (data_rsp_i.gnt || pmp_err_q) begin
          ctrl_update_o = 1'b1;
          addr_update   = ~lsu_err_q; // keep the first failing address
          part2_d       = 1'b0;
          ls_fsm_ns     = IDLE;
        end
      end

      WAIT_RVALID_MIS_GNTS_DONE: begin
        lsu_addr_incr_req_o = 1'b1; // hold the second address for addr_last
        if (data_rsp_i.rvalid) begin
          pmp_err_d      = data_rsp_i.pmp_err;
          lsu_err_d      = data_rsp_i.err; // first part was granted, so no PMP error
          addr_update    = ~data_rsp_i.err;
          rdata_update_o = ~we_q;
          ls_fsm_ns      = IDLE;
        end
      end

      default: ls_fsm_ns = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ls_fsm_cs <= IDLE;
      part2_q   <= 1'b0;
      pmp_err_q <= 1'b0;
      lsu_err_q <= 1'b0;
      we_q      <= 1'b0;
    end else begin
      ls_fsm_cs <= ls_fsm_ns;
      part2_q   <= part2_d;
      pmp_err_q <= pmp_err_d;
      lsu_err_q <= lsu_err_d;
      if (ctrl_update_o) begin
        we_q <= lsu_req_i.we;
      end
    end
  end

  // second part reports its aligned word address
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_last_q <= '0;
    end else if (addr_update) begin
      addr_last_q <= lsu_addr_incr_req_o ? addr_w_aligned : lsu_req_i.addr;
    end
  end

  //////////////////////////////
  // status and response
  //////////////////////////////

  assign lsu_req_done_o     = (lsu_go | (ls_fsm_cs != IDLE)) & (ls_fsm_ns == IDLE);
  assign misaligned_part2_o = part2_q;
  assign addr_last_o        = addr_last_q;
  assign busy_o             = (ls_fsm_cs != IDLE);

  assign resp_valid_o = (data_rsp_i.rvalid | pmp_err_q) & (ls_fsm_cs == IDLE);
  assign resp_err_o   = lsu_err_q | data_rsp_i.err | pmp_err_q;
  assign resp_is_wr_o = we_q;

endmodule

/* load_store_unit.sv */
// load/store unit top level for a small 32-bit in-order core
// connects the sequencer and the store and load data paths to the
// execute stage and to the request/grant/rvalid data bus

`include "lsu_macros.svh"

module load_store_unit import lsu_pkg::*; import mem_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  lsu_req_t               lsu_req_i,
  output lsu_rsp_t               lsu_rsp_o,
  output logic                   lsu_req_done_o,
  output logic                   lsu_addr_incr_req_o,
  output logic [`LSU_ADDR_W-1:0] addr_last_o,
  output logic                   busy_o,
  output logic                   perf_load_o,
  output logic                   perf_store_o,
  output data_req_t              data_req_o,
  input  data_rsp_t              data_rsp_i
);

  logic                   bus_req, misaligned_part2;
  logic                   ctrl_update, rdata_update;
  logic                   resp_valid, resp_err, resp_is_wr;
  logic [`LSU_ADDR_W-1:0] addr_last;
  logic [1:0]             access_offset;

  lsu_ctrl_fsm u_ctrl_fsm (
    .clk_i, .rst_ni, .lsu_req_i, .data_rsp_i,
    .bus_req_o          (bus_req),
    .misaligned_part2_o (misaligned_part2),
    .ctrl_update_o      (ctrl_update),
    .rdata_update_o     (rdata_update),
    .resp_valid_o       (resp_valid),
    .resp_err_o         (resp_err),
    .resp_is_wr_o       (resp_is_wr),
    .lsu_req_done_o, .lsu_addr_incr_req_o,
    .addr_last_o        (addr_last),
    .busy_o, .perf_load_o, .perf_store_o
  );

  // the AGU hands over the aligned second word, so part 2 keeps the first offset
  assign access_offset = misaligned_part2 ? addr_last[1:0] : lsu_req_i.addr[1:0];

  lsu_wdata_align u_wdata_align (
    .size_i (lsu_req_i.size), .offset_i (access_offset),
    .misaligned_part2_i (misaligned_part2), .wdata_i (lsu_req_i.wdata),
    .be_o (data_req_o.be), .wdata_o (data_req_o.wdata)
  );

  lsu_rdata_align u_rdata_align (
    .clk_i, .rst_ni, .ctrl_update_i (ctrl_update), .rdata_update_i (rdata_update),
    .size_i (lsu_req_i.size), .sign_ext_i (lsu_req_i.sign_ext),
    .offset_i (access_offset), .rdata_i (data_rsp_i.rdata), .rdata_o (lsu_rsp_o.rdata)
  );

  assign data_req_o.req  = bus_req;
  assign data_req_o.we   = lsu_req_i.we;
  assign data_req_o.addr = {lsu_req_i.addr[`LSU_ADDR_W-1:2], 2'b00};

  assign lsu_rsp_o.resp_valid  = resp_valid;
  assign lsu_rsp_o.rdata_valid = resp_valid & ~resp_err & ~resp_is_wr; // write back
  assign lsu_rsp_o.load_err    = resp_valid & resp_err & ~resp_is_wr;
  assign lsu_rsp_o.store_err   = resp_valid & resp_err & resp_is_wr;
  assign addr_last_o           = addr_last;

endmodule

/* tb_data_mem.sv */
// data memory model of the load/store unit testbench
// 64 words, random grant delay, in-order rvalid 1 to 3 cycles after the grant,
// bus error on one word and PMP error on another

`include "lsu_macros.svh"

module tb_data_mem import mem_pkg::*; #(
  parameter logic [5:0]  ERR_WORD = 6'd60,
  parameter logic [5:0]  PMP_WORD = 6'd63,
  parameter logic [31:0] SEED     = 32'h1
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  data_req_t data_req_i,
  output data_rsp_t data_rsp_o
);

  typedef struct packed {
    logic [31:0]            due;
    logic                   err;
    logic [`LSU_DATA_W-1:0] rdata;
  } rsp_entry_t;

  logic [`LSU_DATA_W-1:0] mem [64];
  logic [31:0]            rnd;
  logic [31:0]            cycle;
  logic [31:0]            last_due;
  logic [1:0]             gnt_wait;  // cycles left before the next grant
  logic                   rvalid_q, err_q;
  logic [`LSU_DATA_W-1:0] rdata_q;
  logic [5:0]             word;
  rsp_entry_t             rsp_q [$];

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // fill pattern over the whole word address
  initial begin
    for (int i = 0; i < 64; i++) begin
      mem[i] = 32'h9e3779b9 * 32'(i + 1);
    end
  end

  assign word               = data_req_i.addr[7:2];
  assign data_rsp_o.pmp_err = data_req_i.req && (word == PMP_WORD);
  assign data_rsp_o.gnt     = data_req_i.req && !data_rsp_o.pmp_err && (gnt_wait == 2'd0);
  assign data_rsp_o.rvalid  = rvalid_q;
  assign data_rsp_o.err     = err_q;
  assign data_rsp_o.rdata   = rdata_q;

  always @(posedge clk_i or negedge rst_ni) begin
    rsp_entry_t entry;
    if (!rst_ni) begin
      rnd      = SEED;
      cycle    = 32'd0;
      last_due = 32'd0;
      rsp_q.delete();
      gnt_wait <= 2'd0;
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
      rdata_q  <= '0;
    end else begin
      cycle = cycle + 32'd1;
      // return responses strictly in grant order
      if (rsp_q.size() > 0 && rsp_q[0].due <= cycle) begin
        rvalid_q <= 1'b1;
        err_q    <= rsp_q[0].err;
        rdata_q  <= rsp_q[0].rdata;
        void'(rsp_q.pop_front());
      end else begin
        rvalid_q <= 1'b0;
      end
      if (data_rsp_o.gnt) begin
        entry.err = (word == ERR_WORD);
        if (data_req_i.we && !entry.err) begin
          for (int k = 0; k < `LSU_BE_W; k++) begin
            if (data_req_i.be[k]) mem[word][8*k +: 8] = data_req_i.wdata[8*k +: 8];
          end
        end
        entry.rdata = mem[word];
        rnd         = xorshift(rnd);
        entry.due   = cycle + 32'd1 + (rnd % 32'd3);
        if (entry.due <= last_due) entry.due = last_due + 32'd1;
        last_due = entry.due;
        rsp_q.push_back(entry);
        rnd      = xorshift(rnd);
        gnt_wait <= rnd[1:0];
      end else if (data_req_i.req && !data_rsp_o.pmp_err) begin
        gnt_wait <= gnt_wait - 2'd1;
      end
    end
  end

endmodule

/* tb_load_store_unit.sv */
// testbench of the load/store unit
// runs directed and random loads and stores against tb_data_mem and checks
// every response against a byte-level scoreboard of the memory

`include "lsu_macros.svh"

module tb_load_store_unit import lsu_pkg::*; import mem_pkg::*; ();

  localparam logic [5:0] ERR_WORD = 6'd60;
  localparam logic [5:0] PMP_WORD = 6'd63;
  localparam int         TIMEOUT  = 100;

  logic                   clk_i, rst_ni;
  lsu_req_t               lsu_req;
  lsu_rsp_t               lsu_rsp;
  logic                   req_done, addr_incr, busy, perf_load, perf_store;
  logic [`LSU_ADDR_W-1:0] addr_last;
  data_req_t              data_req;
  data_rsp_t              data_rsp;

  logic [31:0]            model [64];  // scoreboard copy of the memory
  logic [31:0]            rnd;
  int                     n_load, n_store, n_resp, n_acc;
  logic                   incr_seen;
  logic [31:0]            gnt_addr [$];

  load_store_unit DUT (
    .clk_i, .rst_ni,
    .lsu_req_i (lsu_req), .lsu_rsp_o (lsu_rsp),
    .lsu_req_done_o (req_done), .lsu_addr_incr_req_o (addr_incr),
    .addr_last_o (addr_last), .busy_o (busy),
    .perf_load_o (perf_load), .perf_store_o (perf_store),
    .data_req_o (data_req), .data_rsp_i (data_rsp)
  );

  tb_data_mem #(.ERR_WORD(ERR_WORD), .PMP_WORD(PMP_WORD), .SEED(32'h24d652d3)) u_mem (
    .clk_i, .rst_ni, .data_req_i (data_req), .data_rsp_o (data_rsp)
  );

  always #5 clk_i = ~clk_i;

  //////////////////////////////
  // checking helpers
  //////////////////////////////

  task automatic fail_now(input string msg);
    $display("TESTS FAILED");
    $display("%s", msg);
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else fail_now($sformatf("** Error: %s expected %h actual %h",
                                                 name, exp, act));
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // back-pressure holds the bus request and its payload
  a_req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_req.req && !data_rsp.gnt && !data_rsp.pmp_err |=>
      busy && data_req.req && $stable(data_req.addr) && $stable(data_req.be)
      && $stable(data_req.wdata))
    else fail_now("bus request dropped or changed before its grant");
  a_done_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_done |=> !req_done)
    else fail_now("lsu_req_done_o high for more than one cycle");

  // strobe and grant monitor, sampled away from the clock edge
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (perf_load) n_load++;
      if (perf_store) n_store++;
      if (lsu_rsp.resp_valid) n_resp++;
      if (addr_incr) incr_seen = 1'b1;
      if (data_req.req && data_rsp.gnt) gnt_addr.push_back(data_req.addr);
    end
  end

  //////////////////////////////
  // one access, start to response
  //////////////////////////////

  task automatic run_access(input string name, input logic we, input lsu_size_e size,
                            input logic sext, input logic [7:0] addr, input logic [31:0] wdata);
    int          nb, n, load0, store0;
    logic        split, err0, err1, exp_err, done_seen, got;
    logic [7:0]  a;
    logic [31:0] first, second, exp_rdata, exp_last;
    lsu_rsp_t    rsp;
    logic [31:0] last;
    nb      = (size == SIZE_WORD) ? 4 : (size == SIZE_HALF) ? 2 : 1;
    split   = (int'(addr[1:0]) + nb) > 4;
    err0    = (addr[7:2] == ERR_WORD) || (addr[7:2] == PMP_WORD);
    err1    = split && ((addr[7:2] + 6'd1 == ERR_WORD) || (addr[7:2] + 6'd1 == PMP_WORD));
    exp_err = err0 || err1;
    first   = {24'h0, addr};
    second  = {24'h0, addr[7:2], 2'b00} + 32'd4;
    exp_last = (err0 || !split) ? first : second;
    exp_rdata = '0;
    for (int k = 0; k < nb; k++) begin
      a = addr + 8'(k);
      exp_rdata[8*k +: 8] = model[a[7:2]][8*a[1:0] +: 8];
      if (we && a[7:2] != ERR_WORD && a[7:2] != PMP_WORD) begin
        model[a[7:2]][8*a[1:0] +: 8] = wdata[8*k +: 8];
      end
    end
    if (sext && nb == 2 && exp_rdata[15]) exp_rdata[31:16] = 16'hffff;
    if (sext && nb == 1 && exp_rdata[7]) exp_rdata[31:8] = 24'hffffff;

    @(posedge clk_i);
    #1;
    check_value({name, " response count"}, 32'(n_acc), 32'(n_resp));
    n_acc++;
    load0  = n_load;
    store0 = n_store;
    gnt_addr.delete();
    incr_seen = 1'b0;
    lsu_req = '{req: 1'b1, we: we, size: size, sign_ext: sext, addr: first, wdata: wdata};

    // the AGU swaps in the second word while the unit asks for it
    n = 0;
    done_seen = 1'b0;
    while (!done_seen) begin
      @(negedge clk_i);
      done_seen = req_done;
      @(posedge clk_i);
      #1;
      if (done_seen) lsu_req.req = 1'b0;
      else lsu_req.addr = addr_incr ? second : first;
      n++;
      if (n > TIMEOUT) fail_now($sformatf("%s: lsu_req_done_o never came", name));
    end
    n = 0;
    got = 1'b0;
    while (!got) begin
      @(negedge clk_i);
      if (lsu_rsp.resp_valid) begin
        got  = 1'b1;
        rsp  = lsu_rsp;
        last = addr_last;
      end
      n++;
      if (n > TIMEOUT) fail_now($sformatf("%s: resp_valid never came", name));
    end
    @(posedge clk_i);
    #1;
    check_value({name, " rdata_valid"}, 32'(!we && !exp_err), 32'(rsp.rdata_valid));
    check_value({name, " load_err"}, 32'(!we && exp_err), 32'(rsp.load_err));
    check_value({name, " store_err"}, 32'(we && exp_err), 32'(rsp.store_err));
    if (!we && !exp_err) check_value({name, " rdata"}, exp_rdata, rsp.rdata);
    check_value({name, " addr_last"}, exp_last, last);
    check_value({name, " perf_load"}, 32'(!we), 32'(n_load - load0));
    check_value({name, " perf_store"}, 32'(we), 32'(n_store - store0));
    check_value({name, " addr_incr"}, 32'(split), 32'(incr_seen));
    check_value({name, " grants"},
                (addr[7:2] == PMP_WORD) ? 32'd0 : split ? 32'd2 : 32'd1,
                32'(gnt_addr.size()));
    if (gnt_addr.size() > 0) check_value({name, " first word"}, first & ~32'd3, gnt_addr[0]);
    if (gnt_addr.size() > 1) check_value({name, " second word"}, second, gnt_addr[1]);
  endtask

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial begin
    logic [7:0] addr;
    clk_i   = 1'b0;
    rst_ni  = 1'b0;
    lsu_req = '0;
    rnd     = 32'h24d652d3;
    n_load  = 0;
    n_store = 0;
    n_resp  = 0;
    n_acc   = 0;
    incr_seen = 1'b0;
    repeat (10) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    for (int i = 0; i < 64; i++) model[i] = u_mem.mem[i];
    @(negedge clk_i);
    check_value("reset bus req", 32'd0, 32'(data_req.req));
    check_value("reset busy", 32'd0, 32'(busy));
    check_value("reset resp_valid", 32'd0, 32'(lsu_rsp.resp_valid));
    check_value("reset load_err", 32'd0, 32'(lsu_rsp.load_err));
    check_value("reset store_err", 32'd0, 32'(lsu_rsp.store_err));

    run_access("aligned store", 1'b1, SIZE_WORD, 1'b0, 8'h10, 32'hcafe1234);
    run_access("aligned load", 1'b0, SIZE_WORD, 1'b0, 8'h10, 32'h0);

    run_access("ext setup", 1'b1, SIZE_WORD, 1'b0, 8'h20, 32'h80f17f8e);
    run_access("ext setup next", 1'b1, SIZE_WORD, 1'b0, 8'h24, 32'h3c95a4b6);
    for (int off = 0; off < 4; off++) begin
      for (int s = 0; s < 2; s++) begin
        run_access("byte load", 1'b0, SIZE_BYTE, 1'(s), 8'h20 + 8'(off), 32'h0);
        run_access("half load", 1'b0, SIZE_HALF, 1'(s), 8'h20 + 8'(off), 32'h0);
      end
    end

    for (int off = 1; off < 4; off++) begin
      run_access("split word store", 1'b1, SIZE_WORD, 1'b0, 8'h30 + 8'(off), 32'h11223344 * off);
      run_access("split word load", 1'b0, SIZE_WORD, 1'b0, 8'h30 + 8'(off), 32'h0);
    end
    run_access("split half store", 1'b1, SIZE_HALF, 1'b0, 8'h43, 32'h0000a55a);
    run_access("split half load", 1'b0, SIZE_HALF, 1'b1, 8'h43, 32'h0);

    run_access("err load", 1'b0, SIZE_WORD, 1'b0, 8'hf0, 32'h0);
    run_access("err store", 1'b1, SIZE_HALF, 1'b0, 8'hf2, 32'h1234);
    run_access("err first part", 1'b0, SIZE_WORD, 1'b0, 8'hf1, 32'h0);
    run_access("err second part load", 1'b0, SIZE_WORD, 1'b0, 8'hee, 32'h0);
    run_access("err second part store", 1'b1, SIZE_WORD, 1'b0, 8'hed, 32'h55aa55aa);
    run_access("pmp load", 1'b0, SIZE_WORD, 1'b0, 8'hfc, 32'h0);
    run_access("pmp store", 1'b1, SIZE_WORD, 1'b0, 8'hfc, 32'h77777777);

    // random mix away from the error words
    for (int i = 0; i < 200; i++) begin
      lsu_size_e size;
      logic      we, sext;
      logic [31:0] wdata;
      rnd   = xorshift(rnd);
      addr  = 8'((rnd % 32'd58) * 32'd4) + 8'(rnd[9:8]);
      size  = lsu_size_e'(2'(rnd[13:10] % 4'd3));
      we    = rnd[16];
      sext  = rnd[17];
      rnd   = xorshift(rnd);
      wdata = rnd;
      run_access("random access", we, size, sext, addr, wdata);
    end

    repeat (5) @(posedge clk_i);
    #1;
    check_value("final response count", 32'(n_acc), 32'(n_resp));
    $display("TESTS PASSED");
    $finish;
  end

endmodule

/* flist.f */
+incdir+.
lsu_pkg.sv
mem_pkg.sv
lsu_wdata_align.sv
lsu_rdata_align.sv
lsu_ctrl_fsm.sv
load_store_unit.sv
tb_data_mem.sv
tb_load_store_unit.sv

/* Makefile */
TOP = tb_load_store_unit

.PHONY: all run lint clean

all: run

run:
	verilator --binary --assert --top-module $(TOP) -f flist.f
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f flist.f

clean:
	rm -rf obj_dir
